// File: vlog.f
ahb_pkg.sv
mfp_map_pkg.sv
ahb_slave_if.sv
ahb_interconnect.sv
ahb_ram.sv
ahb_gpio.sv
mfp_ahb_lite_matrix.sv
tb_mfp_ahb_lite_matrix.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f vlog.f \
    --top-module tb_mfp_ahb_lite_matrix \
    -o sim_tb

output=$(./obj_dir/sim_tb || true)
echo "$output"

echo "$output" | grep -q "Simulation finished: PASS"

// File: tb_mfp_ahb_lite_matrix.sv
`timescale 1ns/1ns

module tb_mfp_ahb_lite_matrix
    import ahb_pkg::*;
    import mfp_map_pkg::*;
();

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 10;
    localparam int RST_WORDS    = 2**(RESET_RAM_ADDR_WIDTH-2);
    localparam int RAM_WORDS    = 2**(RAM_ADDR_WIDTH-2);
    localparam int N_RANDOM     = 400;
    localparam int N_PARTIAL    = 64;
    localparam int N_TRANSFERS  = RST_WORDS + RAM_WORDS + 3*N_RANDOM + 2*N_PARTIAL
                                  + 3*GPIO_COUNT + 6;
    localparam int TIMEOUT_NS   = (RESET_CYCLES + 4*N_TRANSFERS) * CLK_PERIOD;

    localparam int REGION_RESET_RAM = 0;
    localparam int REGION_RAM       = 1;
    localparam int REGION_GPIO      = 2;
    localparam int REGION_NONE      = 3;

    localparam haddr_t RESET_RAM_BASE = 32'h1fc0_0000;
    localparam haddr_t RAM_BASE       = 32'h0000_0000;
    localparam haddr_t UNMAPPED_A     = 32'h1000_0000;
    localparam haddr_t UNMAPPED_B     = 32'h0c00_0004;

    typedef struct packed {
        int        accept_cycle;
        int        region;
        logic      is_read;
        gpio_idx_t idx;
        hdata_t    wdata;
        hdata_t    exp_data;
    } xfer_t;

    logic                    hclk = 1'b0;
    logic                    rst_n;
    haddr_t                  haddr;
    htrans_t                 htrans;
    hsize_t                  hsize;
    logic                    hwrite;
    hdata_t                  hwdata;
    hdata_t                  hrdata;
    logic                    hready;
    hresp_t                  hresp;
    hdata_t [GPIO_COUNT-1:0] gpio_rd;
    hdata_t                  gpio_wd;
    logic [GPIO_COUNT-1:0]   gpio_we;

    logic [31:0] lcg_state = 32'd26;
    int          cycle = 0;
    int          held_cycles = 0;
    int          err_waits = 0;
    hdata_t      next_hwdata = '0;
    hdata_t      gpio_wd_model = '0;
    hdata_t      rst_model [int];
    hdata_t      ram_model [int];
    xfer_t       exp_q [$];

    mfp_ahb_lite_matrix i_mfp_ahb_lite_matrix (
        .hclk    ( hclk    ),
        .rst_n   ( rst_n   ),
        .haddr   ( haddr   ),
        .htrans  ( htrans  ),
        .hsize   ( hsize   ),
        .hwrite  ( hwrite  ),
        .hwdata  ( hwdata  ),
        .hrdata  ( hrdata  ),
        .hready  ( hready  ),
        .hresp   ( hresp   ),
        .gpio_rd ( gpio_rd ),
        .gpio_wd ( gpio_wd ),
        .gpio_we ( gpio_we )
    );

    always #(CLK_PERIOD/2) hclk = ~hclk;

    always @(posedge hclk) begin
        cycle <= cycle + 1;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int region_of(haddr_t a);
        if (a[28:22] == 7'h7f) return REGION_RESET_RAM;
        if (a[28:22] == 7'h7e) return REGION_GPIO;
        if (a[28:26] == 3'b000) return REGION_RAM;
        return REGION_NONE;
    endfunction

    // Random address in a region's window with random alias bits
    function automatic haddr_t random_addr(int region, hsize_t size);
        haddr_t a;
        a = next_random();
        if (region == REGION_RESET_RAM) a[28:22] = 7'h7f;
        else if (region == REGION_RAM) a[28:26] = 3'b000;
        else a[28:22] = 7'h7e;
        if (size == HALF) a[0] = 1'b0;
        else if (size == WORD) a[1:0] = 2'b00;
        return a;
    endfunction

    // Same memory offset with fresh alias bits
    function automatic haddr_t relocate(int region, haddr_t a);
        haddr_t b;
        b = random_addr(region, WORD);
        if (region == REGION_RAM && region_of(a) == REGION_RAM)
            b[RAM_ADDR_WIDTH-1:0] = a[RAM_ADDR_WIDTH-1:0];
        else
            b[RESET_RAM_ADDR_WIDTH-1:0] = a[RESET_RAM_ADDR_WIDTH-1:0];
        return b;
    endfunction

    // Little-endian lanes covered by an aligned transfer of 2**size bytes
    function automatic logic [3:0] lane_enable(hsize_t size, logic [1:0] low);
        logic [3:0] en;
        int         nbytes;
        int         first;
        nbytes = 1 << int'(size);
        first  = int'(low) - (int'(low) % nbytes);
        for (int b = 0; b < 4; b++) en[b] = (b >= first) && (b < first + nbytes);
        return en;
    endfunction

    function automatic hdata_t merge_lanes(hdata_t old, hdata_t data, logic [3:0] en);
        hdata_t word;
        word = old;
        for (int b = 0; b < 4; b++) begin
            if (en[b]) word[8*b +: 8] = data[8*b +: 8];
        end
        return word;
    endfunction

    task automatic model_write(input haddr_t a, input hsize_t size, input hdata_t data);
        logic [3:0] en;
        int         k;
        en = lane_enable(size, a[1:0]);
        if (region_of(a) == REGION_RESET_RAM) begin
            k = int'(a[31:2]) % RST_WORDS;
            rst_model[k] = merge_lanes(rst_model.exists(k) ? rst_model[k] : '0, data, en);
        end else if (region_of(a) == REGION_RAM) begin
            k = int'(a[31:2]) % RAM_WORDS;
            ram_model[k] = merge_lanes(ram_model.exists(k) ? ram_model[k] : '0, data, en);
        end
    endtask

    // Expected read word for any mapped address
    function automatic hdata_t expected_read(haddr_t a);
        case (region_of(a))
            REGION_RESET_RAM: return rst_model[int'(a[31:2]) % RST_WORDS];
            REGION_RAM:       return ram_model[int'(a[31:2]) % RAM_WORDS];
            REGION_GPIO:      return gpio_rd[a[3:2]];
            default:          return '0;
        endcase
    endfunction

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_data(input string name, input hdata_t got, input hdata_t exp);
        if (got !== exp)
            stop_with_failure($sformatf("CHECK FAILED: %s got 0x%08h expected 0x%08h",
                                        name, got, exp));
    endtask

    task automatic check_resp(input string name, input hresp_t got, input hresp_t exp);
        if (got !== exp)
            stop_with_failure($sformatf("CHECK FAILED: %s got 0x%0h expected 0x%0h",
                                        name, got, exp));
    endtask

    task automatic check_gpio(input logic [GPIO_COUNT-1:0] we, input logic [GPIO_COUNT-1:0] we_exp,
                              input hdata_t wd, input hdata_t wd_exp);
        if (we !== we_exp)
            stop_with_failure($sformatf("CHECK FAILED: gpio_we got 0x%0h expected 0x%0h",
                                        we, we_exp));
        check_data("gpio_wd", wd, wd_exp);
    endtask

    // Hold the address phase until hready and send write data one cycle later
    task automatic do_transfer(input haddr_t a, input hsize_t size, input logic write,
                               input hdata_t data);
        xfer_t x;
        logic  accepted;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge hclk);
            hwdata = next_hwdata;
            haddr  = a;
            htrans = NONSEQ;
            hsize  = size;
            hwrite = write;
            accepted = hready;
            if (!accepted) held_cycles++;
        end
        x.accept_cycle = cycle + 1;
        x.region       = region_of(a);
        x.is_read      = !write;
        x.idx          = a[3:2];
        x.wdata        = data;
        x.exp_data     = '0;
        if (write) begin
            model_write(a, size, data);
            next_hwdata = data;
        end else begin
            x.exp_data = expected_read(a);
        end
        exp_q.push_back(x);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge hclk);
            hwdata = next_hwdata;
            htrans = IDLE;
        end
    endtask

    task automatic check_cycle();
        xfer_t                 x;
        logic [GPIO_COUNT-1:0] we_exp;
        we_exp = '0;
        if (exp_q.size() != 0) x = exp_q[0];
        if (exp_q.size() != 0 && x.accept_cycle <= cycle) begin
            if (x.region == REGION_GPIO && !x.is_read)
                for (int i = 0; i < GPIO_COUNT; i++) we_exp[i] = (i == int'(x.idx));
            check_gpio(gpio_we, we_exp, gpio_wd, gpio_wd_model);
            if (x.region == REGION_NONE) begin
                check_resp("hresp", hresp, ERROR);
                if (!hready) begin
                    err_waits++;
                end else begin
                    if (err_waits != 1)
                        stop_with_failure("Error response did not have exactly one wait cycle");
                    err_waits = 0;
                    void'(exp_q.pop_front());
                end
            end else begin
                if (!hready) stop_with_failure("hready went low during a mapped transfer");
                check_resp("hresp", hresp, OKAY);
                if (x.is_read) check_data("hrdata", hrdata, x.exp_data);
                if (we_exp != '0) gpio_wd_model = x.wdata;
                void'(exp_q.pop_front());
            end
        end else begin
            check_gpio(gpio_we, '0, gpio_wd, gpio_wd_model);
            if (!hready) stop_with_failure("hready low with no transfer in its data phase");
            check_resp("hresp", hresp, OKAY);
        end
    endtask

    task automatic init_memories();
        for (int i = 0; i < RST_WORDS; i++)
            do_transfer(RESET_RAM_BASE + (haddr_t'(i) << 2), WORD, 1'b1, next_random());
        for (int i = 0; i < RAM_WORDS; i++)
            do_transfer(RAM_BASE + (haddr_t'(i) << 2), WORD, 1'b1, next_random());
    endtask

    task automatic random_word_traffic();
        logic [31:0] r;
        int          region;
        haddr_t      a;
        repeat (N_RANDOM) begin
            r = next_random();
            region = r[8] ? REGION_RAM : REGION_RESET_RAM;
            a = random_addr(region, WORD);
            if (r[9]) begin
                do_transfer(a, WORD, 1'b1, next_random());
                if (r[10]) do_transfer(relocate(region, a), WORD, 1'b0, '0);
                // Other memory at the same offset stays untouched
                if (r[11]) do_transfer(relocate(REGION_RAM + REGION_RESET_RAM - region, a),
                                       WORD, 1'b0, '0);
            end else begin
                do_transfer(a, WORD, 1'b0, '0);
            end
        end
    endtask

    task automatic partial_writes();
        logic [31:0] r;
        int          region;
        hsize_t      size;
        haddr_t      a;
        haddr_t      rb;
        repeat (N_PARTIAL) begin
            r = next_random();
            region = r[8] ? REGION_RAM : REGION_RESET_RAM;
            size = r[9] ? HALF : BYTE;
            a = random_addr(region, size);
            rb = relocate(region, a);
            rb[1:0] = 2'b00;
            do_transfer(a, size, 1'b1, next_random());
            // Without the idle cycle the read goes through the bypass
            if (r[10]) idle_cycles(1);
            do_transfer(rb, WORD, 1'b0, '0);
        end
    endtask

    task automatic gpio_access();
        haddr_t a;
        for (int i = 0; i < GPIO_COUNT; i++) begin
            a = random_addr(REGION_GPIO, WORD);
            a[3:2] = gpio_idx_t'(i);
            do_transfer(a, WORD, 1'b1, next_random());
            idle_cycles(1);
        end
        for (int i = 0; i < GPIO_COUNT; i++) begin
            repeat (2) begin
                a = random_addr(REGION_GPIO, WORD);
                a[3:2] = gpio_idx_t'(i);
                do_transfer(a, WORD, 1'b0, '0);
            end
        end
    endtask

    task automatic unmapped_access();
        int     held_before;
        haddr_t a;
        held_before = held_cycles;
        do_transfer(UNMAPPED_A, WORD, 1'b0, '0);
        do_transfer(random_addr(REGION_RAM, WORD), WORD, 1'b0, '0);
        a = random_addr(REGION_RESET_RAM, WORD);
        do_transfer(UNMAPPED_B, WORD, 1'b1, next_random());
        do_transfer(a, WORD, 1'b1, next_random());
        do_transfer(a, WORD, 1'b0, '0);
        if (held_cycles - held_before != 2)
            stop_with_failure("Transfers after an unmapped address were not held one cycle");
    endtask

    initial begin
        rst_n  = 1'b0;
        haddr  = '0;
        htrans = IDLE;
        hsize  = WORD;
        hwrite = 1'b0;
        hwdata = '0;
        for (int i = 0; i < GPIO_COUNT; i++) gpio_rd[i] = next_random();
        repeat (RESET_CYCLES) @(posedge hclk);
        @(negedge hclk);
        rst_n = 1'b1;
        idle_cycles(2);
        init_memories();
        random_word_traffic();
        partial_writes();
        gpio_access();
        unmapped_access();
        idle_cycles(4);
        if (exp_q.size() != 0) begin
            stop_with_failure("Some transfers never completed their data phase");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

    // Compare at each falling edge
    initial begin
        wait (rst_n);
        forever begin
            @(negedge hclk);
            check_cycle();
        end
    end

    initial begin
        #(TIMEOUT_NS);
        stop_with_failure("Timeout: the run did not finish in the expected time");
    end

endmodule

// File: mfp_ahb_lite_matrix.sv
`timescale 1ns/1ns

module mfp_ahb_lite_matrix
    import ahb_pkg::*;
    import mfp_map_pkg::*;
(
    input  logic                    hclk,
    input  logic                    rst_n,
    input  haddr_t                  haddr,
    input  htrans_t                 htrans,
    input  hsize_t                  hsize,
    input  logic                    hwrite,
    input  hdata_t                  hwdata,
    output hdata_t                  hrdata,
    output logic                    hready,
    output hresp_t                  hresp,
    input  hdata_t [GPIO_COUNT-1:0] gpio_rd,
    output hdata_t                  gpio_wd,
    output logic [GPIO_COUNT-1:0]   gpio_we
);

    // One bus per slave port
    ahb_slave_if slv_if [SLAVE_COUNT] ();

    ahb_interconnect i_interconnect (
        .hclk   ( hclk   ),
        .rst_n  ( rst_n  ),
        .haddr  ( haddr  ),
        .htrans ( htrans ),
        .hsize  ( hsize  ),
        .hwrite ( hwrite ),
        .hwdata ( hwdata ),
        .hrdata ( hrdata ),
        .hready ( hready ),
        .hresp  ( hresp  ),
        .slv    ( slv_if )
    );

    ahb_ram #(
        .ADDR_WIDTH ( RESET_RAM_ADDR_WIDTH )
    ) reset_ram (
        .hclk  ( hclk                  ),
        .rst_n ( rst_n                 ),
        .s     ( slv_if[SLV_RESET_RAM] )
    );

    ahb_ram #(
        .ADDR_WIDTH ( RAM_ADDR_WIDTH )
    ) ram (
        .hclk  ( hclk            ),
        .rst_n ( rst_n           ),
        .s     ( slv_if[SLV_RAM] )
    );

    ahb_gpio gpio (
        .hclk    ( hclk             ),
        .rst_n   ( rst_n            ),
        .s       ( slv_if[SLV_GPIO] ),
        .gpio_rd ( gpio_rd          ),
        .gpio_wd ( gpio_wd          ),
        .gpio_we ( gpio_we          )
    );

endmodule

// File: ahb_gpio.sv
`timescale 1ns/1ns

module ahb_gpio
    import ahb_pkg::*;
    import mfp_map_pkg::*;
(
    input  logic                    hclk,
    input  logic                    rst_n,
    ahb_slave_if.slave              s,
    input  hdata_t [GPIO_COUNT-1:0] gpio_rd,
    output hdata_t                  gpio_wd,
    output logic [GPIO_COUNT-1:0]   gpio_we
);

    logic      accept;
    logic      d_write;
    gpio_idx_t d_idx;

    assign accept = s.hsel && s.hready && (s.htrans == NONSEQ || s.htrans == SEQ);

    always_ff @(posedge hclk) begin
        if (!rst_n) begin
            d_write <= 1'b0;
        end else if (s.hready) begin
            d_write <= accept && s.hwrite;
        end
    end

    // Word index from bits 3:2
    always_ff @(posedge hclk) begin
        if (accept) begin
            d_idx <= s.haddr[3:2];
        end
    end

    // Output word held until the next write
    always_ff @(posedge hclk) begin
        if (!rst_n) begin
            gpio_wd <= '0;
        end else if (d_write && s.hready) begin
            gpio_wd <= s.hwdata;
        end
    end

    // Strobe only during the write data phase
    assign gpio_we = d_write ? (GPIO_COUNT'(1) << d_idx) : '0;

    assign s.hrdata    = gpio_rd[d_idx];
    assign s.hreadyout = 1'b1;
    assign s.hresp     = OKAY;

endmodule

// File: ahb_ram.sv
`timescale 1ns/1ns

module ahb_ram
    import ahb_pkg::*;
#(
    parameter int ADDR_WIDTH = 12
)(
    input  logic       hclk,
    input  logic       rst_n,
    ahb_slave_if.slave s
);

    hdata_t                   mem [2**(ADDR_WIDTH-2)];

    logic                     accept;
    logic [HDATA_WIDTH/8-1:0] a_be;
    logic [ADDR_WIDTH-3:0]    a_index;

    logic                     d_write;
    logic [HDATA_WIDTH/8-1:0] d_be;
    logic [ADDR_WIDTH-3:0]    d_index;

    hdata_t                   rd_word;
    hdata_t                   rd_data;
    logic                     byp_hit;
    logic [HDATA_WIDTH/8-1:0] byp_be;
    hdata_t                   byp_data;

    assign accept  = s.hsel && s.hready && (s.htrans == NONSEQ || s.htrans == SEQ);
    // Upper address bits are ignored, so the memory aliases in its window
    assign a_index = s.haddr[ADDR_WIDTH-1:2];

    // Little-endian byte lanes
    always_comb begin
        case (s.hsize)
            BYTE:    a_be = 4'b0001 << s.haddr[1:0];
            HALF:    a_be = 4'b0011 << {s.haddr[1], 1'b0};
            default: a_be = 4'b1111;
        endcase
    end

    always_ff @(posedge hclk) begin
        if (!rst_n) begin
            d_write <= 1'b0;
            byp_hit <= 1'b0;
        end else if (s.hready) begin
            d_write <= accept && s.hwrite;
            byp_hit <= accept && !s.hwrite && d_write && (d_index == a_index);
        end
    end

    always_ff @(posedge hclk) begin
        if (accept) begin
            d_be    <= a_be;
            d_index <= a_index;
        end
        if (s.hready) begin
            byp_be   <= d_be;
            byp_data <= s.hwdata;
        end
    end

    // Write lands at the end of the data phase
    always_ff @(posedge hclk) begin
        if (d_write && s.hready) begin
            for (int b = 0; b < HDATA_WIDTH/8; b++) begin
                if (d_be[b]) begin
                    mem[d_index][8*b +: 8] <= s.hwdata[8*b +: 8];
                end
            end
        end
        if (accept && !s.hwrite) begin
            rd_word <= mem[a_index];
        end
    end

    // Read right after a write to the same word sees the written lanes
    always_comb begin
        for (int b = 0; b < HDATA_WIDTH/8; b++) begin
            rd_data[8*b +: 8] = (byp_hit && byp_be[b]) ? byp_data[8*b +: 8]
                                                       : rd_word[8*b +: 8];
        end
    end

    assign s.hrdata    = rd_data;
    assign s.hreadyout = 1'b1;
    assign s.hresp     = OKAY;

    a_size_legal: assert property (@(posedge hclk) disable iff (!rst_n)
        accept |-> s.hsize <= WORD);

    a_half_aligned: assert property (@(posedge hclk) disable iff (!rst_n)
        (accept && s.hsize == HALF) |-> !s.haddr[0]);

    a_no_wait: assert property (@(posedge hclk) disable iff (!rst_n)
        s.hreadyout);

endmodule

// File: ahb_interconnect.sv
`timescale 1ns/1ns

module ahb_interconnect
    import ahb_pkg::*;
    import mfp_map_pkg::*;
(
    input  logic        hclk,
    input  logic        rst_n,
    input  haddr_t      haddr,
    input  htrans_t     htrans,
    input  hsize_t      hsize,
    input  logic        hwrite,
    input  hdata_t      hwdata,
    output hdata_t      hrdata,
    output logic        hready,
    output hresp_t      hresp,
    ahb_slave_if.master slv [SLAVE_COUNT]
);

    typedef enum logic [1:0] {
        ERR_IDLE,
        ERR_WAIT,
        ERR_LAST
    } err_state_t;

    logic [SLAVE_COUNT-1:0] dec_hit;
    slave_idx_t             dec_idx;
    logic                   accept;

    logic                   d_valid;
    slave_idx_t             d_sel;
    err_state_t             err_state;

    hdata_t                 slv_rdata [SLAVE_COUNT];
    logic [SLAVE_COUNT-1:0] slv_ready;
    hresp_t                 slv_resp  [SLAVE_COUNT];

    // Decode on physical address bits
    assign dec_hit[SLV_RESET_RAM] = (haddr[28:22] == RESET_RAM_MATCH);
    assign dec_hit[SLV_RAM]       = (haddr[28:26] == RAM_MATCH);
    assign dec_hit[SLV_GPIO]      = (haddr[28:22] == GPIO_MATCH);

    always_comb begin
        dec_idx = SLV_RESET_RAM;
        for (int i = 0; i < SLAVE_COUNT; i++) begin
            if (dec_hit[i]) begin
                dec_idx = slave_idx_t'(i);
            end
        end
    end

    assign accept = hready && (htrans == NONSEQ || htrans == SEQ);

    for (genvar i = 0; i < SLAVE_COUNT; i++) begin : g_slv
        assign slv[i].haddr  = haddr;
        assign slv[i].htrans = htrans;
        assign slv[i].hsize  = hsize;
        assign slv[i].hwrite = hwrite;
        assign slv[i].hwdata = hwdata;
        assign slv[i].hsel   = dec_hit[i];
        assign slv[i].hready = hready;

        assign slv_rdata[i] = slv[i].hrdata;
        assign slv_ready[i] = slv[i].hreadyout;
        assign slv_resp[i]  = slv[i].hresp;
    end

    // Data phase owner and default error slave
    always_ff @(posedge hclk) begin
        if (!rst_n) begin
            d_valid   <= 1'b0;
            err_state <= ERR_IDLE;
        end else if (err_state == ERR_WAIT) begin
            err_state <= ERR_LAST;
        end else if (hready) begin
            d_valid   <= accept && (|dec_hit);
            err_state <= (accept && !(|dec_hit)) ? ERR_WAIT : ERR_IDLE;
        end
    end

    always_ff @(posedge hclk) begin
        if (accept) begin
            d_sel <= dec_idx;
        end
    end

    always_comb begin
        hrdata = '0;
        hready = 1'b1;
        hresp  = OKAY;
        if (d_valid) begin
            hrdata = slv_rdata[d_sel];
            hready = slv_ready[d_sel];
            hresp  = slv_resp[d_sel];
        end
        case (err_state)
            ERR_WAIT: begin
                hready = 1'b0;
                hresp  = ERROR;
            end
            ERR_LAST: begin
                hready = 1'b1;
                hresp  = ERROR;
            end
            default: ;
        endcase
    end

    a_one_hsel: assert property (@(posedge hclk) disable iff (!rst_n)
        $onehot0(dec_hit));

    // Two-cycle error response
    a_err_two_cycle: assert property (@(posedge hclk) disable iff (!rst_n)
        (hresp == ERROR && !hready) |=> (hresp == ERROR && hready));

endmodule

// File: ahb_slave_if.sv
`timescale 1ns/1ns

interface ahb_slave_if
    import ahb_pkg::*;
();

    // Address phase and write data
    haddr_t  haddr;
    htrans_t htrans;
    hsize_t  hsize;
    logic    hwrite;
    hdata_t  hwdata;
    logic    hsel;
    logic    hready;

    // Slave response
    hdata_t  hrdata;
    logic    hreadyout;
    hresp_t  hresp;

    modport master (
        output haddr, htrans, hsize, hwrite, hwdata, hsel, hready,
        input  hrdata, hreadyout, hresp
    );

    modport slave (
        input  haddr, htrans, hsize, hwrite, hwdata, hsel, hready,
        output hrdata, hreadyout, hresp
    );

endinterface

// File: mfp_map_pkg.sv
package mfp_map_pkg;

    // Slave ports of the matrix
    typedef enum logic [1:0] {
        SLV_RESET_RAM = 2'd0,
        SLV_RAM       = 2'd1,
        SLV_GPIO      = 2'd2
    } slave_idx_t;

    localparam int SLAVE_COUNT = 3;

    // Reset memory at 0x1fc00000 to 0x1fffffff matched on bits 28:22
    localparam logic [6:0] RESET_RAM_MATCH = 7'h7f;

    // Main RAM at 0x00000000 to 0x03ffffff matched on bits 28:26
    localparam logic [2:0] RAM_MATCH = 3'h0;

    // GPIO at 0x1f800000 to 0x1fbfffff matched on bits 28:22
    localparam logic [6:0] GPIO_MATCH = 7'h7e;

    // Byte address widths of the memories
    localparam int RESET_RAM_ADDR_WIDTH = 10;
    localparam int RAM_ADDR_WIDTH       = 12;

    // GPIO words in each direction
    localparam int GPIO_COUNT = 4;

    // Word index from address bits 3:2
    typedef logic [1:0] gpio_idx_t;

endpackage

// File: ahb_pkg.sv
package ahb_pkg;

    // Bus widths
    localparam int HADDR_WIDTH = 32;
    localparam int HDATA_WIDTH = 32;

    typedef logic [HADDR_WIDTH-1:0] haddr_t;
    typedef logic [HDATA_WIDTH-1:0] hdata_t;

    // Transfer type
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_t;

    // Transfer size up to one word
    typedef enum logic [2:0] {
        BYTE = 3'b000,
        HALF = 3'b001,
        WORD = 3'b010
    } hsize_t;

    // Slave response
    typedef enum logic {
        OKAY  = 1'b0,
        ERROR = 1'b1
    } hresp_t;

endpackage
